// ==== logic/i3c_ddr_pkg.sv ====
`default_nettype none

package i3c_ddr_pkg;

  // rx modes, codes as used by the DDR controller
  typedef enum logic [3:0] {
    PREAMBLE     = 4'b0000,
    DESER_BYTE   = 4'b0011,
    CHECK_TOKEN  = 4'b0101,
    CHECK_PARITY = 4'b0110,
    CHECK_CRC    = 4'b0111
  } rx_mode_e;

  typedef logic [7:0]  ddr_byte_t;
  typedef logic [15:0] ddr_word_t;
  typedef logic [4:0]  crc5_t;

  // one sampled SDA bit per SCL edge
  typedef struct packed {
    logic valid;
    logic sda;
  } bit_strobe_t;

  // one entry per received word or CRC word
  typedef struct packed {
    logic      word_valid;
    ddr_word_t word;
    logic      parity_err;
    logic      token_err;
    logic      crc_err;
    logic      frame_end;
  } rx_result_t;

  localparam logic [3:0] DDR_TOKEN = 4'b1100;
  localparam crc5_t      CRC5_INIT = 5'h1F;
  // x^5 + x^2 + 1
  localparam crc5_t      CRC5_POLY = 5'h05;

endpackage

`default_nettype wire

// ==== logic/rx_axil_pkg.sv ====
`default_nettype none

package rx_axil_pkg;

  typedef logic [3:0]  axil_addr_t;
  typedef logic [31:0] axil_data_t;

  // master to slave
  typedef struct packed {
    logic       awvalid;
    axil_addr_t awaddr;
    logic       wvalid;
    axil_data_t wdata;
    logic       bready;
    logic       arvalid;
    axil_addr_t araddr;
    logic       rready;
  } axil_req_t;

  // slave to master
  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
    logic       arready;
    logic       rvalid;
    axil_data_t rdata;
    logic [1:0] rresp;
  } axil_rsp_t;

  localparam axil_addr_t REG_STATUS  = 4'h0;
  localparam axil_addr_t REG_DATA    = 4'h4;
  localparam int         FIFO_DEPTH  = 4;
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// ==== logic/ddr_bit_sampler.sv ====
`timescale 1ns/1ns
`default_nettype none

module ddr_bit_sampler
  import i3c_ddr_pkg::*;
(
  input  logic        i_sys_clk,
  input  logic        i_sys_rst,
  input  logic        i_scl,
  input  logic        i_sda,
  output bit_strobe_t o_strobe
);

  logic [1:0] scl_sync;
  logic [1:0] sda_sync;
  logic       scl_d;

  // SCL idles high, so the chain starts high to avoid a false edge
  always_ff @(posedge i_sys_clk or negedge i_sys_rst)
  begin
    if (!i_sys_rst)
    begin
      scl_sync <= 2'b11;
      sda_sync <= 2'b11;
      scl_d    <= 1'b1;
      o_strobe <= '0;
    end
    else
    begin
      scl_sync       <= {scl_sync[0], i_scl};
      sda_sync       <= {sda_sync[0], i_sda};
      scl_d          <= scl_sync[1];
      // either edge carries a bit in DDR mode
      o_strobe.valid <= scl_sync[1] ^ scl_d;
      o_strobe.sda   <= sda_sync[1];
    end
  end

  // SCL half period is far longer than one system cycle
  a_strobe_single: assert property (
    @(posedge i_sys_clk) disable iff (!i_sys_rst)
    o_strobe.valid |=> !o_strobe.valid
  );

endmodule

`default_nettype wire

// ==== logic/ddr_crc5.sv ====
`timescale 1ns/1ns
`default_nettype none

module ddr_crc5
  import i3c_ddr_pkg::*;
(
  input  logic  i_sys_clk,
  input  logic  i_sys_rst,
  input  logic  i_clear,
  input  logic  i_bit_valid,
  input  logic  i_bit,
  output crc5_t o_crc
);

  logic feedback;

  assign feedback = o_crc[4] ^ i_bit;

  // serial LFSR, one data bit per update
  always_ff @(posedge i_sys_clk or negedge i_sys_rst)
  begin
    if (!i_sys_rst)
      o_crc <= CRC5_INIT;
    else if (i_clear)
      o_crc <= CRC5_INIT;
    else if (i_bit_valid)
      o_crc <= {o_crc[3:0], 1'b0} ^ (feedback ? CRC5_POLY : 5'd0);
  end

endmodule

`default_nettype wire

// ==== logic/ddr_rx_shifter.sv ====
`timescale 1ns/1ns
`default_nettype none

module ddr_rx_shifter
  import i3c_ddr_pkg::*;
(
  input  logic        i_sys_clk,
  input  logic        i_sys_rst,
  input  bit_strobe_t i_strobe,
  input  rx_mode_e    i_mode,
  input  crc5_t       i_crc,
  output logic        o_field_done,
  output logic        o_crc_bit_valid,
  output logic        o_crc_bit,
  output logic        o_word_valid,
  output logic        o_parity_err,
  output logic        o_token_err,
  output logic        o_crc_err,
  output logic        o_preamble,
  output ddr_word_t   o_word
);

  rx_mode_e   mode_q;
  logic [2:0] cnt;
  logic [2:0] cnt_eff;
  logic [2:0] last_idx;
  logic       field_last;
  logic       byte_sel;
  ddr_byte_t  field_sr;
  ddr_byte_t  field_nxt;
  ddr_word_t  word_q;
  logic [1:0] par_calc;

  // index of the last bit in each field
  always_comb
  begin
    case (i_mode)
      PREAMBLE:     last_idx = 3'd1;
      DESER_BYTE:   last_idx = 3'd7;
      CHECK_TOKEN:  last_idx = 3'd3;
      CHECK_PARITY: last_idx = 3'd1;
      CHECK_CRC:    last_idx = 3'd4;
      default:      last_idx = 3'd7;
    endcase
  end

  // a new mode always starts counting from bit 0
  assign cnt_eff    = (i_mode != mode_q) ? 3'd0 : cnt;
  assign field_nxt  = {field_sr[6:0], i_strobe.sda};
  assign field_last = i_strobe.valid && (cnt_eff == last_idx);

  // P1 over the odd bits, P0 over the even bits inverted
  assign par_calc[1] = ^(word_q & 16'hAAAA);
  assign par_calc[0] = ~^(word_q & 16'h5555);

  assign o_word = word_q;

  always_ff @(posedge i_sys_clk or negedge i_sys_rst)
  begin
    if (!i_sys_rst)
    begin
      mode_q          <= PREAMBLE;
      cnt             <= 3'd0;
      byte_sel        <= 1'b0;
      o_field_done    <= 1'b0;
      o_crc_bit_valid <= 1'b0;
      o_crc_bit       <= 1'b0;
      o_word_valid    <= 1'b0;
      o_parity_err    <= 1'b0;
      o_token_err     <= 1'b0;
      o_crc_err       <= 1'b0;
      o_preamble      <= 1'b0;
    end
    else
    begin
      mode_q          <= i_mode;
      o_field_done    <= field_last;
      o_crc_bit_valid <= i_strobe.valid && (i_mode == DESER_BYTE);
      o_crc_bit       <= i_strobe.sda;
      if (i_strobe.valid)
        cnt <= field_last ? 3'd0 : cnt_eff + 3'd1;
      else
        cnt <= cnt_eff;
      if (field_last)
      begin
        case (i_mode)
          PREAMBLE:
          begin
            // first bit picks data or CRC, second bit must be 1
            o_preamble   <= field_sr[0];
            o_token_err  <= ~i_strobe.sda;
            o_word_valid <= 1'b0;
            byte_sel     <= 1'b0;
          end
          DESER_BYTE:
          begin
            byte_sel <= ~byte_sel;
            if (byte_sel)
              o_word_valid <= 1'b1;
          end
          CHECK_TOKEN:  o_token_err  <= (field_nxt[3:0] != DDR_TOKEN);
          CHECK_PARITY: o_parity_err <= (field_nxt[1:0] != par_calc);
          CHECK_CRC:    o_crc_err    <= (field_nxt[4:0] != i_crc);
          default:      o_token_err  <= 1'b1;
        endcase
      end
    end
  end

  // field bits and the assembled word, MSB first
  always_ff @(posedge i_sys_clk)
  begin
    if (i_strobe.valid)
      field_sr <= field_nxt;
    if (field_last && (i_mode == DESER_BYTE))
      word_q <= {word_q[7:0], field_nxt};
  end

endmodule

`default_nettype wire

// ==== logic/ddr_frame_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module ddr_frame_ctrl
  import i3c_ddr_pkg::*;
(
  input  logic       i_sys_clk,
  input  logic       i_sys_rst,
  input  logic       i_field_done,
  input  logic       i_preamble,
  input  logic       i_word_valid,
  input  logic       i_parity_err,
  input  logic       i_token_err,
  input  logic       i_crc_err,
  input  ddr_word_t  i_word,
  output rx_mode_e   o_mode,
  output logic       o_crc_clear,
  output rx_result_t o_result
);

  typedef enum logic [2:0] {
    ST_PRE,
    ST_BYTE_HI,
    ST_BYTE_LO,
    ST_PARITY,
    ST_TOKEN,
    ST_CRC
  } ctrl_state_e;

  ctrl_state_e state;

  always_comb
  begin
    case (state)
      ST_BYTE_HI: o_mode = DESER_BYTE;
      ST_BYTE_LO: o_mode = DESER_BYTE;
      ST_PARITY:  o_mode = CHECK_PARITY;
      ST_TOKEN:   o_mode = CHECK_TOKEN;
      ST_CRC:     o_mode = CHECK_CRC;
      default:    o_mode = PREAMBLE;
    endcase
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst)
  begin
    if (!i_sys_rst)
    begin
      state       <= ST_PRE;
      o_crc_clear <= 1'b0;
      o_result    <= '0;
    end
    else
    begin
      o_result    <= '0;
      o_crc_clear <= 1'b0;
      if (i_field_done)
      begin
        case (state)
          ST_PRE:
          begin
            // bad preamble, report it and wait for the next word
            if (i_token_err)
            begin
              o_result.token_err <= 1'b1;
              o_crc_clear        <= 1'b1;
            end
            else if (i_preamble)
              state <= ST_BYTE_HI;
            else
              state <= ST_TOKEN;
          end
          ST_BYTE_HI: state <= ST_BYTE_LO;
          ST_BYTE_LO: state <= ST_PARITY;
          ST_PARITY:
          begin
            o_result.word_valid <= i_word_valid;
            o_result.word       <= i_word;
            o_result.parity_err <= i_parity_err;
            state               <= ST_PRE;
          end
          ST_TOKEN: state <= ST_CRC;
          ST_CRC:
          begin
            // end of frame, the CRC restarts for the next one
            o_result.frame_end <= 1'b1;
            o_result.token_err <= i_token_err;
            o_result.crc_err   <= i_crc_err;
            o_crc_clear        <= 1'b1;
            state              <= ST_PRE;
          end
          default: state <= ST_PRE;
        endcase
      end
    end
  end

  // a CRC word never carries data bytes after its token
  a_no_byte_after_token: assert property (
    @(posedge i_sys_clk) disable iff (!i_sys_rst)
    (o_mode == CHECK_TOKEN) |=> (o_mode != DESER_BYTE)
  );

endmodule

`default_nettype wire

// ==== logic/rx_axil_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module rx_axil_regs
  import i3c_ddr_pkg::*, rx_axil_pkg::*;
(
  input  logic       i_sys_clk,
  input  logic       i_sys_rst,
  input  rx_result_t i_result,
  input  axil_req_t  i_axil,
  output axil_rsp_t  o_axil
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  ddr_word_t    fifo_mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   fifo_cnt;
  logic         fifo_empty;
  logic         fifo_full;
  logic         push;
  logic         pop;
  logic         ovf_set;
  // overflow, frame end, crc, token, parity
  logic [4:0]   sticky;
  logic [4:0]   set_mask;
  logic [4:0]   clr_mask;
  axil_data_t   status_word;
  logic         aw_held;
  logic         w_held;
  logic         bvalid_q;
  logic         wr_fire;
  axil_addr_t   awaddr_q;
  axil_data_t   wdata_q;
  logic         ar_hs;
  logic         r_hs;
  logic         rvalid_q;
  logic         rd_pop_q;
  axil_data_t   rdata_q;
  logic [1:0]   rresp_q;

  assign fifo_empty  = (fifo_cnt == '0);
  assign fifo_full   = (fifo_cnt == (PTR_W + 1)'(FIFO_DEPTH));
  assign push        = i_result.word_valid && !fifo_full;
  assign ovf_set     = i_result.word_valid && fifo_full;
  assign ar_hs       = i_axil.arvalid && !rvalid_q;
  assign r_hs        = rvalid_q && i_axil.rready;
  assign pop         = r_hs && rd_pop_q;
  assign wr_fire     = aw_held && w_held && !bvalid_q;
  assign set_mask    = {ovf_set, i_result.frame_end, i_result.crc_err,
                        i_result.token_err, i_result.parity_err};
  assign clr_mask    = (wr_fire && (awaddr_q == REG_STATUS)) ? wdata_q[5:1] : 5'd0;
  assign status_word = {26'd0, sticky, !fifo_empty};

  always_comb
  begin
    o_axil.awready = !aw_held && !bvalid_q;
    o_axil.wready  = !w_held && !bvalid_q;
    o_axil.bvalid  = bvalid_q;
    o_axil.bresp   = RESP_OKAY;
    o_axil.arready = !rvalid_q;
    o_axil.rvalid  = rvalid_q;
    o_axil.rdata   = rdata_q;
    o_axil.rresp   = rresp_q;
  end

  always_ff @(posedge i_sys_clk or negedge i_sys_rst)
  begin
    if (!i_sys_rst)
    begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      fifo_cnt <= '0;
      sticky   <= '0;
      aw_held  <= 1'b0;
      w_held   <= 1'b0;
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
      rd_pop_q <= 1'b0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop)
        fifo_cnt <= fifo_cnt + 1'b1;
      else if (pop && !push)
        fifo_cnt <= fifo_cnt - 1'b1;
      // write-one-to-clear, a new event in the same cycle wins
      sticky <= (sticky & ~clr_mask) | set_mask;
      // AW and W in either order, B once both are in
      if (i_axil.awvalid && o_axil.awready)
        aw_held <= 1'b1;
      if (i_axil.wvalid && o_axil.wready)
        w_held <= 1'b1;
      if (wr_fire)
      begin
        bvalid_q <= 1'b1;
        aw_held  <= 1'b0;
        w_held   <= 1'b0;
      end
      else if (bvalid_q && i_axil.bready)
        bvalid_q <= 1'b0;
      if (ar_hs)
      begin
        rvalid_q <= 1'b1;
        rd_pop_q <= (i_axil.araddr == REG_DATA) && !fifo_empty;
      end
      else if (r_hs)
      begin
        rvalid_q <= 1'b0;
        rd_pop_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_sys_clk)
  begin
    if (push)
      fifo_mem[wr_ptr] <= i_result.word;
    if (i_axil.awvalid && o_axil.awready)
      awaddr_q <= i_axil.awaddr;
    if (i_axil.wvalid && o_axil.wready)
      wdata_q <= i_axil.wdata;
    if (ar_hs)
    begin
      case (i_axil.araddr)
        REG_STATUS:
        begin
          rdata_q <= status_word;
          rresp_q <= RESP_OKAY;
        end
        REG_DATA:
        begin
          // head stays in place until the R handshake
          rdata_q <= fifo_empty ? '0 : {16'd0, fifo_mem[rd_ptr]};
          rresp_q <= fifo_empty ? RESP_SLVERR : RESP_OKAY;
        end
        default:
        begin
          rdata_q <= '0;
          rresp_q <= RESP_SLVERR;
        end
      endcase
    end
  end

  a_rvalid_hold: assert property (
    @(posedge i_sys_clk) disable iff (!i_sys_rst)
    (o_axil.rvalid && !i_axil.rready) |=> (o_axil.rvalid && $stable(o_axil.rdata))
  );

endmodule

`default_nettype wire

// ==== logic/i3c_ddr_rx_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module i3c_ddr_rx_top
  import i3c_ddr_pkg::*, rx_axil_pkg::*;
(
  input  logic      i_sys_clk,
  input  logic      i_sys_rst,
  input  logic      i_scl,
  input  logic      i_sda,
  input  axil_req_t i_axil,
  output axil_rsp_t o_axil
);

  bit_strobe_t strobe;
  rx_mode_e    mode;
  crc5_t       crc;
  ddr_word_t   word;
  rx_result_t  result;
  logic        field_done;
  logic        crc_bit_valid;
  logic        crc_bit;
  logic        crc_clear;
  logic        word_valid;
  logic        parity_err;
  logic        token_err;
  logic        crc_err;
  logic        preamble;

  // input side
  ddr_bit_sampler u_ddr_bit_sampler (
    .i_sys_clk (i_sys_clk),
    .i_sys_rst (i_sys_rst),
    .i_scl     (i_scl),
    .i_sda     (i_sda),
    .o_strobe  (strobe)
  );

  ddr_frame_ctrl u_ddr_frame_ctrl (
    .i_sys_clk    (i_sys_clk),
    .i_sys_rst    (i_sys_rst),
    .i_field_done (field_done),
    .i_preamble   (preamble),
    .i_word_valid (word_valid),
    .i_parity_err (parity_err),
    .i_token_err  (token_err),
    .i_crc_err    (crc_err),
    .i_word       (word),
    .o_mode       (mode),
    .o_crc_clear  (crc_clear),
    .o_result     (result)
  );

  ddr_rx_shifter u_ddr_rx_shifter (
    .i_sys_clk       (i_sys_clk),
    .i_sys_rst       (i_sys_rst),
    .i_strobe        (strobe),
    .i_mode          (mode),
    .i_crc           (crc),
    .o_field_done    (field_done),
    .o_crc_bit_valid (crc_bit_valid),
    .o_crc_bit       (crc_bit),
    .o_word_valid    (word_valid),
    .o_parity_err    (parity_err),
    .o_token_err     (token_err),
    .o_crc_err       (crc_err),
    .o_preamble      (preamble),
    .o_word          (word)
  );

  ddr_crc5 u_ddr_crc5 (
    .i_sys_clk   (i_sys_clk),
    .i_sys_rst   (i_sys_rst),
    .i_clear     (crc_clear),
    .i_bit_valid (crc_bit_valid),
    .i_bit       (crc_bit),
    .o_crc       (crc)
  );

  // host side
  rx_axil_regs u_rx_axil_regs (
    .i_sys_clk (i_sys_clk),
    .i_sys_rst (i_sys_rst),
    .i_result  (result),
    .i_axil    (i_axil),
    .o_axil    (o_axil)
  );

endmodule

`default_nettype wire

// ==== tests/tb_clk_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen
(
  output logic o_sys_clk,
  output logic o_sys_rst
);

  localparam int HALF_NS    = 10;
  localparam int RST_CYCLES = 10;

  initial
  begin
    o_sys_clk = 1'b0;
    forever #HALF_NS o_sys_clk = ~o_sys_clk;
  end

  // active low, released just after a rising edge
  initial
  begin
    o_sys_rst = 1'b0;
    repeat (RST_CYCLES) @(posedge o_sys_clk);
    #2;
    o_sys_rst = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tests/tb_i3c_ddr_rx.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_i3c_ddr_rx
  import i3c_ddr_pkg::*, rx_axil_pkg::*;
();

  localparam int DRV_NS      = 2;
  localparam int HALF_CYCLES = 10;
  // sampler 3, shifter 1, controller 1, FIFO push 1, plus slack
  localparam int PIPE_CYCLES = 8;
  localparam int DATA_WORDS  = 11;
  localparam int CRC_WORDS   = 3;
  localparam int BIT_NS      = HALF_CYCLES * 20;
  localparam int TIMEOUT_NS  = 2 * (DATA_WORDS * 20 + CRC_WORDS * 11) * BIT_NS + 20000;

  logic      sys_clk;
  logic      sys_rst;
  logic      scl;
  logic      sda;
  axil_req_t axil_req;
  axil_rsp_t axil_rsp;
  integer    seed;
  crc5_t     crc_model;
  ddr_word_t sent_q[$];

  tb_clk_gen u_tb_clk_gen (
    .o_sys_clk (sys_clk),
    .o_sys_rst (sys_rst)
  );

  i3c_ddr_rx_top u_i3c_ddr_rx_top (
    .i_sys_clk (sys_clk),
    .i_sys_rst (sys_rst),
    .i_scl     (scl),
    .i_sda     (sda),
    .i_axil    (axil_req),
    .o_axil    (axil_rsp)
  );

  task automatic abort_run;
    begin
      $display("Regression failed");
      $fatal(1, "stopping at the first error");
    end
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    begin
      assert (got === exp)
      else
      begin
        $display("[FAIL] t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
        abort_run();
      end
    end
  endtask

  // x^5 + x^2 + 1 with data MSB first
  function automatic crc5_t crc_step(input crc5_t c, input logic b);
    logic  fb;
    crc5_t n;
    begin
      fb   = c[4] ^ b;
      n[0] = fb;
      n[1] = c[0];
      n[2] = c[1] ^ fb;
      n[3] = c[2];
      n[4] = c[3];
      return n;
    end
  endfunction

  // {P1, P0} with P1 over odd bits and P0 over even bits inverted
  function automatic logic [1:0] parity_bits(input ddr_word_t w);
    logic p1;
    logic p0;
    begin
      p1 = 1'b0;
      p0 = 1'b1;
      for (int i = 0; i < 16; i += 2)
      begin
        p0 = p0 ^ w[i];
        p1 = p1 ^ w[i + 1];
      end
      return {p1, p0};
    end
  endfunction

  // one SCL edge per bit with SDA set mid-half
  task automatic send_bit(input logic b);
    begin
      sda = b;
      repeat (HALF_CYCLES / 2) @(posedge sys_clk);
      #DRV_NS;
      scl = ~scl;
      repeat (HALF_CYCLES / 2) @(posedge sys_clk);
      #DRV_NS;
    end
  endtask

  task automatic send_data_word(input ddr_word_t w, input logic bad_p0);
    logic [1:0] par;
    begin
      par = parity_bits(w);
      send_bit(1'b1);
      send_bit(1'b1);
      for (int i = 15; i >= 0; i--)
      begin
        send_bit(w[i]);
        crc_model = crc_step(crc_model, w[i]);
      end
      send_bit(par[1]);
      send_bit(par[0] ^ bad_p0);
      sent_q.push_back(w);
    end
  endtask

  task automatic send_crc_word(input logic [3:0] token, input crc5_t flip);
    crc5_t crc_field;
    begin
      crc_field = crc_model ^ flip;
      send_bit(1'b0);
      send_bit(1'b1);
      for (int i = 3; i >= 0; i--)
        send_bit(token[i]);
      for (int i = 4; i >= 0; i--)
        send_bit(crc_field[i]);
      crc_model = CRC5_INIT;
    end
  endtask

  task automatic random_word(output ddr_word_t w);
    logic [31:0] r;
    begin
      r = $random(seed);
      w = r[15:0];
    end
  endtask

  task automatic settle;
    begin
      repeat (PIPE_CYCLES) @(posedge sys_clk);
      #DRV_NS;
    end
  endtask

  task automatic axil_write(input axil_addr_t addr, input axil_data_t data);
    logic aw_hs;
    logic w_hs;
    begin
      axil_req.awvalid = 1'b1;
      axil_req.awaddr  = addr;
      axil_req.wvalid  = 1'b1;
      axil_req.wdata   = data;
      while (axil_req.awvalid || axil_req.wvalid)
      begin
        aw_hs = axil_req.awvalid && axil_rsp.awready;
        w_hs  = axil_req.wvalid && axil_rsp.wready;
        @(posedge sys_clk);
        #DRV_NS;
        if (aw_hs)
          axil_req.awvalid = 1'b0;
        if (w_hs)
          axil_req.wvalid = 1'b0;
      end
      axil_req.bready = 1'b1;
      while (!axil_rsp.bvalid)
      begin
        @(posedge sys_clk);
        #DRV_NS;
      end
      compare_value("bresp", 32'(axil_rsp.bresp), 32'(RESP_OKAY));
      // a pending B response blocks the next AW
      compare_value("awready", 32'(axil_rsp.awready), 32'd0);
      @(posedge sys_clk);
      #DRV_NS;
      axil_req.bready = 1'b0;
    end
  endtask

  // stall keeps RREADY low for that many cycles once RVALID is up
  task automatic check_read(input axil_addr_t addr, input axil_data_t exp_data,
                            input logic [1:0] exp_resp, input int stall);
    axil_data_t held;
    begin
      axil_req.arvalid = 1'b1;
      axil_req.araddr  = addr;
      while (!axil_rsp.arready)
      begin
        @(posedge sys_clk);
        #DRV_NS;
      end
      @(posedge sys_clk);
      #DRV_NS;
      axil_req.arvalid = 1'b0;
      while (!axil_rsp.rvalid)
      begin
        @(posedge sys_clk);
        #DRV_NS;
      end
      held = axil_rsp.rdata;
      // a pending R response blocks the next AR
      compare_value("arready", 32'(axil_rsp.arready), 32'd0);
      repeat (stall)
      begin
        @(posedge sys_clk);
        #DRV_NS;
        compare_value("rvalid", 32'(axil_rsp.rvalid), 32'd1);
        compare_value("rdata held", axil_rsp.rdata, held);
      end
      compare_value("rdata", axil_rsp.rdata, exp_data);
      compare_value("rresp", 32'(axil_rsp.rresp), 32'(exp_resp));
      axil_req.rready = 1'b1;
      @(posedge sys_clk);
      #DRV_NS;
      axil_req.rready = 1'b0;
    end
  endtask

  task automatic check_next_word(input int stall);
    ddr_word_t exp;
    begin
      exp = sent_q.pop_front();
      check_read(REG_DATA, {16'd0, exp}, RESP_OKAY, stall);
    end
  endtask

  initial
  begin
    #(TIMEOUT_NS);
    $display("timeout, no end of test after %0d ns", TIMEOUT_NS);
    abort_run();
  end

  initial
  begin
    ddr_word_t w;
    seed      = 32'hc4b8_f7ec;
    crc_model = CRC5_INIT;
    scl       = 1'b1;
    sda       = 1'b1;
    axil_req  = '0;
    @(posedge sys_rst);
    @(posedge sys_clk);
    #DRV_NS;

    // idle bus straight after reset
    compare_value("rvalid", 32'(axil_rsp.rvalid), 32'd0);
    compare_value("bvalid", 32'(axil_rsp.bvalid), 32'd0);
    check_read(REG_STATUS, 32'h0, RESP_OKAY, 0);

    // three words and a good CRC word
    repeat (3)
    begin
      random_word(w);
      send_data_word(w, 1'b0);
    end
    send_crc_word(DDR_TOKEN, 5'h00);
    settle();
    repeat (3) check_next_word(0);
    check_read(REG_STATUS, 32'h10, RESP_OKAY, 0);
    axil_write(REG_STATUS, 32'h10);
    check_read(REG_STATUS, 32'h0, RESP_OKAY, 0);

    // inverted P0 cleared by writing one
    random_word(w);
    send_data_word(w, 1'b1);
    settle();
    check_read(REG_STATUS, 32'h3, RESP_OKAY, 0);
    axil_write(REG_STATUS, 32'h2);
    check_read(REG_STATUS, 32'h1, RESP_OKAY, 0);
    check_next_word(0);

    // wrong CRC field followed by a wrong token
    send_crc_word(DDR_TOKEN, 5'h01);
    settle();
    check_read(REG_STATUS, 32'h18, RESP_OKAY, 0);
    send_crc_word(4'b1010, 5'h00);
    settle();
    check_read(REG_STATUS, 32'h1C, RESP_OKAY, 0);
    axil_write(REG_STATUS, 32'h3E);
    check_read(REG_STATUS, 32'h0, RESP_OKAY, 0);

    // five words into a four-deep FIFO
    repeat (5)
    begin
      random_word(w);
      send_data_word(w, 1'b0);
    end
    settle();
    check_read(REG_STATUS, 32'h21, RESP_OKAY, 0);
    repeat (4) check_next_word(0);
    // the fifth word was dropped
    sent_q.delete(0);
    check_read(REG_DATA, 32'h0, RESP_SLVERR, 0);
    axil_write(REG_STATUS, 32'h20);

    // host holds RREADY low on the first read
    repeat (2)
    begin
      random_word(w);
      send_data_word(w, 1'b0);
    end
    settle();
    check_next_word(6);
    check_next_word(0);
    check_read(REG_STATUS, 32'h0, RESP_OKAY, 0);

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== i3c_ddr_rx_top.f ====
logic/i3c_ddr_pkg.sv
logic/rx_axil_pkg.sv
logic/ddr_bit_sampler.sv
logic/ddr_crc5.sv
logic/ddr_rx_shifter.sv
logic/ddr_frame_ctrl.sv
logic/rx_axil_regs.sv
logic/i3c_ddr_rx_top.sv
tests/tb_clk_gen.sv
tests/tb_i3c_ddr_rx.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the receive path testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_i3c_ddr_rx -f i3c_ddr_rx_top.f -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log
if grep -q "Regression failed" sim.log; then
  exit 1
fi
grep -q "Regression passed" sim.log
